// ==== hw/mmio_pkg.sv ====
package mmio_pkg;

    // address map, all byte addresses, word aligned
    localparam logic [31:0] reg_limit = 32'd1024;  // first address past the external registers
    localparam logic [31:0] tft_limit = 32'd2048;  // first address past the TFT write window
    localparam logic [31:0] mem_limit = 32'd8192;  // end of memory region, base of fetch window

    // target sizes
    localparam int mem_words = 1536;  // 6 KiB of instruction/data words
    localparam int reg_count = 16;    // external registers, aliased across the region
    localparam int spi_bits  = 32;    // one TFT word per chip select

    // cpu load/store operation
    typedef enum logic [1:0] {
        rwi_write = 2'b01,
        rwi_read  = 2'b10,
        rwi_idle  = 2'b11
    } rwi_e;

    // decoded target of one request
    typedef enum logic [2:0] {
        region_reg   = 3'd0,  // external register file
        region_tft   = 3'd1,  // spi write window
        region_mem   = 3'd2,  // instruction/data memory
        region_fetch = 3'd3,  // memory seen through the fetch window
        region_none  = 3'd4   // nothing mapped here
    } region_e;

    // tft shifter sequencing
    typedef enum logic [1:0] {
        tx_idle  = 2'd0,  // cs_n high, waiting on the buffer
        tx_shift = 2'd1,  // cs_n low, two clocks per bit
        tx_gap   = 2'd2   // single cs_n high cycle between words
    } tx_state_e;

    // request as presented by the cpu each cycle
    typedef struct packed {
        rwi_e        op;     // idle, write or read
        logic [31:0] addr;   // byte address
        logic [31:0] wdata;  // store data
    } mmio_req_t;

    // command into the single-port memory
    typedef struct packed {
        logic                         en;     // access this cycle
        logic                         we;     // write when set, read otherwise
        logic [$clog2(mem_words)-1:0] idx;    // word index
        logic [31:0]                  wdata;  // store data
    } mem_cmd_t;

    // host side load of one external register
    typedef struct packed {
        logic                         en;    // load strobe
        logic [$clog2(reg_count)-1:0] idx;   // register number
        logic [31:0]                  data;  // new register value
    } reg_load_t;

endpackage

// ==== hw/mmio_router.sv ====
`timescale 1ns/1ps

module mmio_router (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::mmio_req_t req,
    input  logic [31:0]         reg_rdata,
    input  logic [31:0]         mem_rdata,
    output logic                reg_rd,
    output logic [3:0]          reg_idx,
    output mmio_pkg::mem_cmd_t  mem_cmd,
    output logic                tft_wr,
    output logic [31:0]         tft_word,
    output logic [31:0]         rd_data,
    output logic                rd_valid,
    output logic [31:0]         instr,
    output logic                instr_valid
);

    import mmio_pkg::*;

    region_e     region;       // target of the current request
    logic [31:0] fetch_off;    // byte offset into the fetch window
    logic [31:0] mem_off;      // byte offset into memory, either view
    logic        is_rd;        // read or fetch this cycle
    logic        is_wr;        // store this cycle
    region_e     pend_region;  // region of the read in flight
    logic        pend_valid;   // a read is in flight
    logic [31:0] sel_data;     // returning word picked by region

    assign is_rd = (req.op == rwi_read);
    assign is_wr = (req.op == rwi_write);

    // address classification
    always_comb begin
        fetch_off = req.addr - mem_limit;
        if (req.addr < reg_limit) begin
            region = region_reg;
        end else if (req.addr < tft_limit) begin
            region = region_tft;
        end else if (req.addr < mem_limit) begin
            region = region_mem;
        end else if (fetch_off < (mem_limit - tft_limit)) begin
            region = region_fetch;  // fetch window is as deep as memory
        end else begin
            region = region_none;
        end
    end

    // memory and fetch views share one word index
    assign mem_off = (region == region_fetch) ? fetch_off : (req.addr - tft_limit);

    // one target strobe per request, or none
    always_comb begin
        reg_rd        = is_rd && (region == region_reg);  // register writes dropped
        reg_idx       = req.addr[5:2];                    // 16 words aliased by index
        tft_wr        = is_wr && (region == region_tft);  // tft reads dropped
        tft_word      = req.wdata;
        mem_cmd       = '0;
        mem_cmd.idx   = mem_off[$clog2(mem_words)+1:2];   // drop byte offset
        mem_cmd.wdata = req.wdata;
        if (region == region_mem) begin
            mem_cmd.en = is_rd || is_wr;
            mem_cmd.we = is_wr;
        end else if (region == region_fetch) begin
            mem_cmd.en = is_rd;  // fetch-window stores are ignored
        end
    end

    // pick the word that came back for the read in flight
    always_comb begin
        case (pend_region)
            region_reg:   sel_data = reg_rdata;
            region_mem:   sel_data = mem_rdata;
            region_fetch: sel_data = mem_rdata;
            default:      sel_data = '0;  // tft or unmapped read answers zero
        endcase
    end

    // one pending stage, then registered result
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid  <= 1'b0;
            pend_region <= region_none;
            rd_valid    <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            pend_valid  <= is_rd;
            pend_region <= region;
            rd_valid    <= pend_valid && (pend_region != region_fetch);
            instr_valid <= pend_valid && (pend_region == region_fetch);
        end
    end

    // result words, zero when nothing is returned
    always_ff @(posedge clk) begin
        if (pend_valid && (pend_region != region_fetch)) begin
            rd_data <= sel_data;
        end else begin
            rd_data <= '0;
        end
        if (pend_valid && (pend_region == region_fetch)) begin
            instr <= sel_data;
        end else begin
            instr <= '0;
        end
    end

endmodule

// ==== hw/ext_reg_file.sv ====
`timescale 1ns/1ps

module ext_reg_file (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::reg_load_t load,
    input  logic                rd,
    input  logic [3:0]          idx,
    output logic [31:0]         rdata
);

    import mmio_pkg::*;

    logic [31:0] regs [reg_count];  // host-visible register bank

    // host load port, takes effect at the sampling edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (load.en) begin
            regs[load.idx] <= load.data;
        end
    end

    // cpu read port
    // a load to the same index on this edge is not seen yet
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= regs[idx];
        end
    end

endmodule

// ==== hw/inst_data_mem.sv ====
`timescale 1ns/1ps

module inst_data_mem (
    input  logic               clk,
    input  mmio_pkg::mem_cmd_t cmd,
    output logic [31:0]        rdata
);

    import mmio_pkg::*;

    logic [31:0] mem [mem_words];  // word array, single port

    // one access per cycle, write or registered read
    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.we) begin
                mem[cmd.idx] <= cmd.wdata;  // store
            end else begin
                rdata <= mem[cmd.idx];      // load or fetch
            end
        end
    end

endmodule

// ==== hw/tft_spi_tx.sv ====
`timescale 1ns/1ps

module tft_spi_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr,
    input  logic [31:0] word,
    output logic        full,
    output logic        sck,
    output logic        mosi,
    output logic        cs_n
);

    import mmio_pkg::*;

    tx_state_e                    state;      // shifter sequencing
    logic [31:0]                  fifo_q [2]; // two-word buffer
    logic                         wr_ptr;     // next free slot
    logic                         rd_ptr;     // oldest word
    logic [1:0]                   count;      // words held, 0 to 2
    logic                         push;       // accepted write
    logic                         pop;        // shifter takes a word
    logic [31:0]                  shift_q;    // word on the wire, msb first
    logic [$clog2(spi_bits)-1:0]  bit_cnt;    // bits already sent
    logic                         sck_q;      // serial clock level

    assign full = (count == 2'd2);
    assign push = wr && !full;  // writes while full are lost
    assign pop  = ((state == tx_idle) || (state == tx_gap)) && (count != 2'd0);

    // buffer pointers and fill level
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // buffer storage
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_q[wr_ptr] <= word;
        end
    end

    // shifter fsm, two clk cycles per bit
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= tx_idle;
            sck_q   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            case (state)
                tx_idle, tx_gap: begin
                    sck_q   <= 1'b0;
                    bit_cnt <= '0;
                    if (pop) begin
                        state <= tx_shift;  // chip select drops next cycle
                    end else begin
                        state <= tx_idle;
                    end
                end
                tx_shift: begin
                    sck_q <= ~sck_q;  // rising edge mid-bit, falling edge ends it
                    if (sck_q) begin
                        if (bit_cnt == ($clog2(spi_bits))'(spi_bits - 1)) begin
                            state <= tx_gap;  // last bit done
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= tx_idle;
                end
            endcase
        end
    end

    // shift register payload
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= fifo_q[rd_ptr];  // load next word
        end else if ((state == tx_shift) && sck_q) begin
            shift_q <= {shift_q[30:0], 1'b0};  // advance on falling sck
        end
    end

    assign sck  = sck_q;
    assign cs_n = (state != tx_shift);
    assign mosi = cs_n ? 1'b0 : shift_q[31];  // quiet line between words

endmodule

// ==== hw/mmio_top.sv ====
`timescale 1ns/1ps

module mmio_top (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::mmio_req_t cpu_req,
    input  mmio_pkg::reg_load_t reg_load,
    output logic [31:0]         rd_data,
    output logic                rd_valid,
    output logic [31:0]         instr,
    output logic                instr_valid,
    output logic                busy,
    output logic                spi_sck,
    output logic                spi_mosi,
    output logic                spi_cs_n
);

    import mmio_pkg::*;

    logic        reg_rd;     // register read strobe
    logic [3:0]  reg_idx;    // register index from address bits 5:2
    logic [31:0] reg_rdata;  // registered register word
    mem_cmd_t    mem_cmd;    // memory access for load, store and fetch
    logic [31:0] mem_rdata;  // registered memory word
    logic        tft_wr;     // tft write strobe
    logic [31:0] tft_word;   // word to send over spi

    // address decode and result steering
    mmio_router i_router (
        .clk         (clk),
        .reset       (reset),
        .req         (cpu_req),
        .reg_rdata   (reg_rdata),
        .mem_rdata   (mem_rdata),
        .reg_rd      (reg_rd),
        .reg_idx     (reg_idx),
        .mem_cmd     (mem_cmd),
        .tft_wr      (tft_wr),
        .tft_word    (tft_word),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    // host-loaded registers
    ext_reg_file i_regs (
        .clk   (clk),
        .reset (reset),
        .load  (reg_load),
        .rd    (reg_rd),
        .idx   (reg_idx),
        .rdata (reg_rdata)
    );

    // instruction/data memory
    inst_data_mem i_mem (
        .clk   (clk),
        .cmd   (mem_cmd),
        .rdata (mem_rdata)
    );

    // tft word stream, full flag is the cpu busy
    tft_spi_tx i_tft (
        .clk   (clk),
        .reset (reset),
        .wr    (tft_wr),
        .word  (tft_word),
        .full  (busy),
        .sck   (spi_sck),
        .mosi  (spi_mosi),
        .cs_n  (spi_cs_n)
    );

endmodule

// ==== dv/mmio_props.sv ====
`timescale 1ns/1ps

module mmio_props (
    input logic                clk,
    input logic                reset,
    input mmio_pkg::mmio_req_t req,
    input logic                reg_rd,
    input mmio_pkg::mem_cmd_t  mem_cmd,
    input logic                tft_wr,
    input logic                rd_valid,
    input logic                instr_valid
);

    import mmio_pkg::*;

    int fail_count = 0;  // failed assertions so far

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({reg_rd, mem_cmd.en, tft_wr}))  // a request reaches one target at most
        else begin
            $error("more than one target strobe in one cycle");
            fail_count++;
        end

    single_valid: assert property (@(posedge clk) disable iff (reset)
        !(rd_valid && instr_valid))
        else begin
            $error("rd_valid and instr_valid high together");
            fail_count++;
        end

    // read sampled at t answers in the cycle after t+1
    read_answered: assert property (@(posedge clk) disable iff (reset)
        (req.op == rwi_read) |-> ##2 (rd_valid ^ instr_valid))
        else begin
            $error("read or fetch not followed by exactly one valid");
            fail_count++;
        end

endmodule

bind mmio_router mmio_props i_props (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .reg_rd      (reg_rd),
    .mem_cmd     (mem_cmd),
    .tft_wr      (tft_wr),
    .rd_valid    (rd_valid),
    .instr_valid (instr_valid)
);

// ==== dv/mmio_tb.sv ====
`timescale 1ns/1ps

module mmio_tb;

    import mmio_pkg::*;

    logic        clk;
    logic        reset;
    mmio_req_t   cpu_req;
    reg_load_t   reg_load;
    logic [31:0] rd_data;
    logic        rd_valid;
    logic [31:0] instr;
    logic        instr_valid;
    logic        busy;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_cs_n;

    logic [7:0]  op_q [$];       // parsed data file, one entry per line
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [31:0] exp_q [$];
    logic [7:0]  rsp_kind [$];   // reads in flight, R or F
    logic [31:0] rsp_word [$];
    int          rsp_due [$];    // cycle count at which the result shows
    logic [31:0] spi_exp [$];    // words still owed on the spi pins
    logic [31:0] spi_word = '0;  // bits collected so far
    int          spi_nbits = 0;
    int          cyc = 0;
    int          limit = 100000;
    int          errors = 0;
    int          checks = 0;
    logic [7:0]  kind;
    logic [31:0] want;
    int          due;

    mmio_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .reg_load    (reg_load),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERROR %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        errors += i_dut.i_router.i_props.fail_count;  // failures of the router assertions
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic drive_line(input logic [7:0] op, input logic [31:0] a,
                              input logic [31:0] d, input logic [31:0] e);
        if (op == "T") begin
            @(posedge clk);
            cpu_req  <= '{op: rwi_idle, addr: '0, wdata: '0};  // let an earlier write land
            reg_load <= '0;
            @(negedge clk);
            while (busy) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        reg_load <= '0;
        case (op)
            "L": begin
                cpu_req  <= '{op: rwi_idle, addr: '0, wdata: '0};
                reg_load <= '{en: 1'b1, idx: a[3:0], data: d};
            end
            "W": cpu_req <= '{op: rwi_write, addr: a, wdata: d};
            "R", "F": begin
                cpu_req <= '{op: rwi_read, addr: a, wdata: '0};
                rsp_kind.push_back(op);
                rsp_word.push_back(e);
                rsp_due.push_back(cyc + 2);  // sampled next edge, valid one edge later
            end
            "T", "B": begin
                cpu_req <= '{op: rwi_write, addr: a, wdata: d};
                if (op == "T" || e == d) begin
                    spi_exp.push_back(e);
                end else begin
                    @(negedge clk);
                    check_value("busy", 32'd1, {31'd0, busy});  // buffer full at the drop
                end
            end
            default: begin
                $display("unknown opcode %c in the test data", op);
                errors++;
            end
        endcase
    endtask

    // result monitor, also the cycle counter
    always @(negedge clk) begin
        if (rd_valid || instr_valid) begin
            if (rsp_kind.size() == 0) begin
                $display("a result came back at %0t with no read outstanding", $time);
                errors++;
            end else begin
                kind = rsp_kind.pop_front();
                want = rsp_word.pop_front();
                due  = rsp_due.pop_front();
                check_value("result cycle", due, cyc);
                check_value("instr_valid", {31'd0, kind == "F"}, {31'd0, instr_valid});
                check_value("rd_valid", {31'd0, kind == "R"}, {31'd0, rd_valid});
                if (kind == "F") begin
                    check_value("instr", want, instr);
                end else begin
                    check_value("rd_data", want, rd_data);
                end
            end
        end else if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
            $display("no result at %0t for a read issued two cycles earlier", $time);
            errors++;
            kind = rsp_kind.pop_front();
            want = rsp_word.pop_front();
            due  = rsp_due.pop_front();
        end
        cyc++;
    end

    // spi word collector, msb first
    always @(posedge spi_sck) begin
        if (!spi_cs_n) begin
            spi_word = {spi_word[30:0], spi_mosi};
            spi_nbits++;
            if (spi_nbits == spi_bits) begin
                spi_nbits = 0;
                if (spi_exp.size() == 0) begin
                    $display("spi word %h at %0t was never written", spi_word, $time);
                    errors++;
                end else begin
                    check_value("spi_mosi word", spi_exp.pop_front(), spi_word);
                end
            end
        end
    end

    initial begin
        #1;
        while (cyc < limit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, the run did not finish", cyc);
        errors++;
        finish_run();
    end

    initial begin
        int          fd;
        int          code;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [8*128-1:0] rest;
        reset    = 1'b1;
        cpu_req  = '{op: rwi_idle, addr: '0, wdata: '0};
        reg_load = '0;
        fd = $fopen("dv/mmio_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/mmio_testdata.txt");
            errors++;
            finish_run();
        end else begin
            code = $fscanf(fd, " %c", op);
            while (code == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);  // column notes
                end else begin
                    code = $fscanf(fd, " %h %h %h", a, d, e);
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                end
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
            limit = op_q.size() * 70 + 200;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            check_value("rd_valid", 32'd0, {31'd0, rd_valid});
            check_value("instr_valid", 32'd0, {31'd0, instr_valid});
            check_value("busy", 32'd0, {31'd0, busy});
            check_value("spi_cs_n", 32'd1, {31'd0, spi_cs_n});
            check_value("spi_sck", 32'd0, {31'd0, spi_sck});
            foreach (op_q[i]) begin
                drive_line(op_q[i], addr_q[i], data_q[i], exp_q[i]);
            end
            @(posedge clk);
            cpu_req <= '{op: rwi_idle, addr: '0, wdata: '0};
            reg_load <= '0;
            while (rsp_kind.size() != 0 || spi_exp.size() != 0) begin
                @(posedge clk);
            end
            repeat (80) @(posedge clk);  // room for a stray spi word
            finish_run();
        end
    end

endmodule

// ==== dv/mmio_testdata.txt ====
# op addr data expected, all hex; L loads register addr, R and F expect rd_data and instr
# T waits for busy low, B does not wait and expects 0 when the write must be dropped
L 00000003 1234abcd 00000000
L 0000000a cafef00d 00000000
R 0000000c 00000000 1234abcd
R 000003cc 00000000 1234abcd
R 000001e8 00000000 cafef00d
W 0000000c 55555555 00000000
R 0000000c 00000000 1234abcd
W 00000800 11111111 00000000
R 00000800 00000000 11111111
W 00000804 22222222 00000000
W 00001ffc 33333333 00000000
R 00000804 00000000 22222222
R 00001ffc 00000000 33333333
R 00000800 00000000 11111111
F 00002004 00000000 22222222
F 000037fc 00000000 33333333
W 00002000 99999999 00000000
F 00002000 00000000 11111111
R 00000400 00000000 00000000
R 00004000 00000000 00000000
T 00000400 a5c30f96 a5c30f96
B 00000404 0badcafe 0badcafe
B 00000408 13579bdf 13579bdf
B 0000040c deadbeef 00000000
T 00000400 80000001 80000001

// ==== all.f ====
hw/mmio_pkg.sv
hw/mmio_router.sv
hw/ext_reg_file.sv
hw/inst_data_mem.sv
hw/tft_spi_tx.sv
hw/mmio_top.sv
dv/mmio_props.sv
dv/mmio_tb.sv
